//--- Makefile
# Verilator build and run of the ISO14443-A front end testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_hi_iso14443a
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the binary exits non-zero when the testbench stops on $$fatal
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_hi_iso14443a.sv
//--------------------------------------------------------------------
// testbench for the ISO14443-A reader and sniffer front end
// drives the ADC stream, mode and downlink, watches the ARM serial
// link and the carrier driver against a reference model
//--------------------------------------------------------------------

`timescale 1ns/1ps

module tb_hi_iso14443a
	import iso14443a_pkg::*;
();

	localparam int clk_period     = 40;
	localparam int reset_cycles   = 16;
	localparam int hyst_high      = 16;
	localparam int hyst_low       = 8;
	localparam int edge_threshold = 5;

	// ticks spent by each part of the sequence below
	localparam int len_reset   = reset_cycles + 1;
	localparam int len_rates   = 32 + 200 + 64 + 400;
	localparam int len_demod   = 4 * 64;
	localparam int len_tx      = 200;
	localparam int len_hyst    = 2 * (64 + 128 + 192);
	localparam int len_deep    = 128 + 192 + 16 + 200;
	localparam int total_ticks = len_reset + len_rates + len_demod + len_tx + len_hyst + len_deep;
	localparam int watchdog_ns = 2 * total_ticks * clk_period;

	logic              ck_1356meg;
	logic              ck_1356megb;
	logic              fdt_reset;
	logic [adc_w-1:0]  adc_d;
	logic [mode_w-1:0] mod_type;
	logic              ssp_dout;
	logic              adc_clk;
	logic              ssp_clk;
	logic              ssp_frame;
	logic              ssp_din;
	logic              pwr_hi;
	logic              dbg;

	// capture state of the serial link, one sample per tick
	int         tick_count;
	int         capture_base;
	int         last_clk_rise;
	int         last_frame_rise;
	int         frame_start;
	int         nbits;
	logic       capturing;
	logic [7:0] shreg;
	logic       prev_clk;
	logic       prev_frame;
	int         clk_gaps[$];
	int         frame_gaps[$];
	int         frame_highs[$];
	logic       fall_bits[$];
	logic [7:0] sniff_bytes[$];
	int         byte_starts[$];

	// expected carrier tick, valid while no reader pause can shift it
	logic [tick_w-1:0] model_tick;
	logic              track_tick;

	// ADC pattern, square wave of 16 ticks or a forced zero run
	int                wave_lo;
	int                wave_hi;
	int                wave_phase;
	int                zeros_left;
	logic [7:0]        lfsr_state;
	logic [mode_w-1:0] cur_mode;

	hi_iso14443a #(
		.hyst_high      (hyst_high),
		.hyst_low       (hyst_low),
		.edge_threshold (edge_threshold)
	) uut (
		.ck_1356meg  (ck_1356meg),
		.ck_1356megb (ck_1356megb),
		.fdt_reset   (fdt_reset),
		.adc_d       (adc_d),
		.mod_type    (mod_type),
		.ssp_dout    (ssp_dout),
		.adc_clk     (adc_clk),
		.ssp_clk     (ssp_clk),
		.ssp_frame   (ssp_frame),
		.ssp_din     (ssp_din),
		.pwr_hi      (pwr_hi),
		.dbg         (dbg)
	);

	// carrier and its inverse
	initial
	begin
		ck_1356meg  = 1'b0;
		ck_1356megb = 1'b1;
		forever
		begin
			#(clk_period / 2);
			ck_1356meg  = ~ck_1356meg;
			ck_1356megb = ~ck_1356megb;
		end
	end

	initial
	begin
		#(watchdog_ns);
		abort_run($sformatf("watchdog expired after %0d ns, the test sequence hung",
			watchdog_ns));
	end

	// ------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------

	// 8 bit fibonacci LFSR, taps 8 6 5 4
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	// schmitt trigger on one sample
	function automatic logic hyst_level(input logic prev_level, input int sample);
		if (sample >= hyst_high)
			return 1'b1;
		else if (sample < hyst_low)
			return 1'b0;
		return prev_level;
	endfunction

	// derivative filter over two periods of the wave, both edge kinds needed
	function automatic logic tag_mod_ref(input int lo, input int hi);
		int s [0:35];
		int filt;
		int top;
		int bottom;
		top    = 0;
		bottom = 0;
		for (int t = 0; t < 36; t++)
			s[t] = ((t % 16) < 8) ? hi : lo;
		for (int t = 4; t < 36; t++)
		begin
			filt = 2 * s[t-4] + s[t-3] - s[t-1] - 2 * s[t];
			if (filt > top)
				top = filt;
			if (filt < bottom)
				bottom = filt;
		end
		return (top > edge_threshold) && (bottom < -edge_threshold);
	endfunction

	// reader nibble then tag nibble, tag side blanked while the reader sends
	function automatic logic [7:0] sniff_byte_ref(input logic reader_lvl, input logic tag_bit,
		input logic deep);
		return {{4{reader_lvl}}, deep ? 4'b0000 : {4{tag_bit}}};
	endfunction

	// carrier driver during the low half of the clock
	function automatic logic pwr_ref(input logic [mode_w-1:0] mode, input logic key);
		if (mode == mode_reader_listen)
			return 1'b1;
		else if (mode == mode_reader_mod)
			return ~key;
		return 1'b0;
	endfunction

	function automatic logic [7:0] next_adc();
		logic [7:0] s;
		if (zeros_left > 0)
		begin
			zeros_left--;
			s = 8'd0;
		end
		else
		begin
			s          = (wave_phase < 8) ? 8'(wave_hi) : 8'(wave_lo);
			wave_phase = (wave_phase + 1) % 16;
		end
		return s;
	endfunction

	// ------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] expected, input string what);
		if (got !== expected)
			abort_run($sformatf("CHECK FAILED at %0t: %s, got 0x%02h expected 0x%02h",
				$time, what, got, expected));
	endtask

	task automatic check_bit(input logic got, input logic expected, input string what);
		if (got !== expected)
			abort_run($sformatf("CHECK FAILED at %0t: %s, got %b expected %b",
				$time, what, got, expected));
	endtask

	task automatic check_period(input int got, input int expected, input string what);
		if (got != expected)
			abort_run($sformatf("CHECK FAILED at %0t: %s, got %0d ticks expected %0d",
				$time, what, got, expected));
	endtask

	task automatic check_rates(input int clk_gap, input int frame_gap, input int frame_high,
		input string what);
		if (clk_gaps.size() == 0 || frame_gaps.size() == 0 || frame_highs.size() == 0)
			abort_run($sformatf("%s: too few ssp_clk or ssp_frame edges were seen", what));
		foreach (clk_gaps[i])
			check_period(clk_gaps[i], clk_gap, {what, " ssp_clk period"});
		foreach (frame_gaps[i])
			check_period(frame_gaps[i], frame_gap, {what, " ssp_frame period"});
		foreach (frame_highs[i])
			check_period(frame_highs[i], frame_high, {what, " ssp_frame high time"});
	endtask

	task automatic check_listen_bits(input logic expected, input string what);
		if (fall_bits.size() == 0)
			abort_run($sformatf("%s: ssp_clk never fell", what));
		foreach (fall_bits[i])
			check_bit(fall_bits[i], expected, what);
	endtask

	// only frames that started no later than last_start count
	task automatic check_sniff_bytes(input logic [7:0] expected, input logic [7:0] mask,
		input int last_start, input string what);
		int seen;
		seen = 0;
		for (int i = 0; i < sniff_bytes.size(); i++)
		begin
			if (byte_starts[i] <= last_start)
			begin
				check_byte(sniff_bytes[i] & mask, expected & mask, what);
				seen++;
			end
		end
		if (seen < 2)
			abort_run($sformatf("%s: only %0d sniffer frames were captured", what, seen));
	endtask

	// ------------------------------------------------------------------
	// stimulus and capture
	// ------------------------------------------------------------------

	task automatic clear_capture();
		clk_gaps.delete();
		frame_gaps.delete();
		frame_highs.delete();
		fall_bits.delete();
		sniff_bytes.delete();
		byte_starts.delete();
		last_clk_rise   = -1;
		last_frame_rise = -1;
		capturing       = 1'b0;
		capture_base    = tick_count;
	endtask

	task automatic set_wave(input int lo, input int hi);
		wave_lo = lo;
		wave_hi = hi;
	endtask

	task automatic apply_reset();
		for (int i = 0; i < reset_cycles; i++)
		begin
			@(posedge ck_1356meg);
			// nothing has been clocked before the first falling edge
			if (i > 0)
			begin
				check_bit(ssp_clk, 1'b0, "ssp_clk during reset");
				check_bit(ssp_frame, 1'b0, "ssp_frame during reset");
				check_bit(ssp_din, 1'b0, "ssp_din during reset");
			end
			@(negedge ck_1356meg);
			#10;
			check_bit(pwr_hi, 1'b0, "pwr_hi during reset");
		end
	endtask

	// outputs move on the falling edge, so the rising edge sees them settled
	task automatic run_ticks(input int n);
		logic       cur_clk;
		logic       cur_frame;
		logic       cur_din;
		logic [7:0] sample;
		logic       key_bit;
		for (int i = 0; i < n; i++)
		begin
			@(posedge ck_1356meg);
			cur_clk   = ssp_clk;
			cur_frame = ssp_frame;
			cur_din   = ssp_din;
			tick_count++;
			// timebase counts from zero after reset, dbg shows its bit 3
			if (track_tick)
				check_bit(dbg, model_tick[3], "dbg against bit 3 of the carrier tick");
			model_tick = model_tick + 1'b1;
			if (cur_clk && !prev_clk)
			begin
				if (last_clk_rise >= 0)
					clk_gaps.push_back(tick_count - last_clk_rise);
				last_clk_rise = tick_count;
			end
			if (cur_frame && !prev_frame)
			begin
				if (last_frame_rise >= 0)
					frame_gaps.push_back(tick_count - last_frame_rise);
				last_frame_rise = tick_count;
				frame_start     = tick_count - capture_base;
				shreg           = 8'h00;
				nbits           = 0;
				capturing       = 1'b1;
			end
			if (!cur_frame && prev_frame && last_frame_rise >= 0)
				frame_highs.push_back(tick_count - last_frame_rise);
			// data is read on the falling ssp_clk, MSB first
			if (!cur_clk && prev_clk)
			begin
				fall_bits.push_back(cur_din);
				if (capturing)
				begin
					shreg = {shreg[6:0], cur_din};
					nbits++;
					if (nbits == 8)
					begin
						sniff_bytes.push_back(shreg);
						byte_starts.push_back(frame_start);
						capturing = 1'b0;
					end
				end
			end
			prev_clk   = cur_clk;
			prev_frame = cur_frame;

			sample = next_adc();
			key_bit = 1'b0;
			if (cur_mode == mode_reader_mod)
			begin
				lfsr_state = lfsr_step(lfsr_state);
				key_bit    = lfsr_state[0];
			end
			adc_d     <= sample;
			mod_type  <= cur_mode;
			ssp_dout  <= key_bit;
			fdt_reset <= 1'b0;

			#10;
			check_bit(pwr_hi, 1'b0, "pwr_hi while the carrier clock is high");
			check_bit(adc_clk, 1'b1, "adc_clk while the carrier clock is high");
			@(negedge ck_1356meg);
			#10;
			check_bit(pwr_hi, pwr_ref(mod_type, key_bit),
				"pwr_hi while the carrier clock is low");
			check_bit(adc_clk, 1'b0, "adc_clk while the carrier clock is low");
		end
	endtask

	// ------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------

	initial
	begin
		fdt_reset  = 1'b1;
		adc_d      = 8'd30;
		mod_type   = mode_sniffer;
		ssp_dout   = 1'b0;
		cur_mode   = mode_sniffer;
		wave_lo    = 30;
		wave_hi    = 30;
		wave_phase = 0;
		zeros_left = 0;
		lfsr_state = 8'd62;
		tick_count = 0;
		model_tick = '0;
		track_tick = 1'b1;
		prev_clk   = 1'b0;
		prev_frame = 1'b0;
		clear_capture();

		apply_reset();

		// serial link rates
		run_ticks(32);
		clear_capture();
		run_ticks(200);
		check_rates(8, 64, 8, "sniffer");
		cur_mode = mode_reader_listen;
		run_ticks(64);
		clear_capture();
		run_ticks(400);
		check_rates(16, 128, 16, "reader listen");

		// tag answer while we are the reader, four windows to settle
		run_ticks(64);
		clear_capture();
		run_ticks(64);
		check_listen_bits(tag_mod_ref(30, 30), "reader listen, steady carrier");
		set_wave(20, 60);
		run_ticks(64);
		clear_capture();
		run_ticks(64);
		check_listen_bits(tag_mod_ref(20, 60), "reader listen, subcarrier");

		// random downlink keys the carrier, checked inside run_ticks
		cur_mode = mode_reader_mod;
		run_ticks(len_tx);

		// level between the thresholds keeps the last decision
		cur_mode = mode_sniffer;
		set_wave(20, 20);
		run_ticks(64);
		set_wave(12, 12);
		run_ticks(128);
		clear_capture();
		run_ticks(192);
		check_sniff_bytes(sniff_byte_ref(hyst_level(hyst_level(1'b1, 20), 12),
			tag_mod_ref(12, 12), 1'b0), 8'hFF, 192, "hysteresis from above");
		set_wave(4, 4);
		run_ticks(64);
		set_wave(12, 12);
		run_ticks(128);
		clear_capture();
		run_ticks(192);
		check_sniff_bytes(sniff_byte_ref(hyst_level(hyst_level(1'b1, 4), 12),
			tag_mod_ref(12, 12), 1'b0), 8'hFF, 192, "hysteresis from below");

		// tag subcarrier on a carrier that never drops out
		set_wave(20, 60);
		run_ticks(128);
		clear_capture();
		run_ticks(192);
		check_sniff_bytes(sniff_byte_ref(hyst_level(hyst_level(1'b1, 60), 20),
			tag_mod_ref(20, 60), 1'b0), 8'hFF, 192, "sniffer tag answer");

		// reader pause, tag nibble stays blank for frames inside 200 ticks
		// the pause lets the timebase slip to the reader's phase
		track_tick = 1'b0;
		zeros_left = 16;
		run_ticks(16);
		clear_capture();
		run_ticks(200);
		check_sniff_bytes(sniff_byte_ref(1'b1, tag_mod_ref(20, 60), 1'b1), 8'h0F,
			200 - 64, "sniffer under deep modulation");

		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- common/iso14443a_pkg.sv
//--------------------------------------------------------------------
// ISO14443-A high frequency front end, shared definitions
// mode codes, data widths and protocol timing constants for the
// reader side and sniffer datapath
//--------------------------------------------------------------------

package iso14443a_pkg;

	// ------------------------------------------------------------------
	// data widths
	// ------------------------------------------------------------------

	// one ADC sample
	parameter int adc_w = 8;
	// signed output of the derivative filter
	parameter int filt_w = 11;
	// carrier tick counter, 128 ticks per ARM byte
	parameter int tick_w = 7;
	// mode select from the ARM
	parameter int mode_w = 3;

	// ------------------------------------------------------------------
	// mode codes
	// ------------------------------------------------------------------

	// tag simulation codes 1 and 2 fall through as idle
	parameter logic [2:0] mode_sniffer       = 3'd0;
	parameter logic [2:0] mode_reader_listen = 3'd3;
	parameter logic [2:0] mode_reader_mod    = 3'd4;

	// ------------------------------------------------------------------
	// protocol timing
	// ------------------------------------------------------------------

	// carrier off this long means the reader is sending
	parameter int deep_mod_ticks = 8;
	// carrier on this long means the reader went quiet
	parameter int deep_idle_ticks = 256;

	// bit slot where the timebase may slip to follow the reader
	parameter logic [3:0] sync_tick = 4'd13;
	// detector window start while we are the reader
	parameter logic [3:0] listen_window_phase = 4'd4;
	// RF + ADC + hysteresis lag, net of the tag response offset
	parameter logic [3:0] sniff_window_offset = 4'd3;

endpackage

//--- design/carrier_timebase.sv
//--------------------------------------------------------------------
// carrier timebase
// 128 tick counter of the carrier clock, nudged into phase with
// the reader's pauses while sniffing
//--------------------------------------------------------------------

`timescale 1ns/1ps

module carrier_timebase
	import iso14443a_pkg::*;
(
	input  logic              ck_1356meg,
	input  logic              fdt_reset,
	input  logic [mode_w-1:0] mod_type,
	input  logic              deep_modulation,
	input  logic              reader_fall,
	output logic [tick_w-1:0] tick,
	output logic              dbg
);

	// slot value that matches neither correction case
	localparam logic [3:0] slot_used = 4'd8;

	// bit slot of the last reader fall
	logic [3:0] fall_slot;
	logic       sync_now;

	// correction only while a reader is active in sniffer mode
	assign sync_now = (tick[3:0] == sync_tick) && (mod_type == mode_sniffer)
		&& deep_modulation;

	always_ff @(negedge ck_1356meg)
	begin
		if (fdt_reset)
		begin
			tick      <= '0;
			fall_slot <= slot_used;
		end
		else
		begin
			if (reader_fall)
				fall_slot <= tick[3:0];

			if (sync_now)
			begin
				// reader edge right after our sample point, sample earlier
				if (fall_slot == 4'd1)
					tick <= tick + 2'd2;
				// reader edge right before it, sample later
				else if (fall_slot == 4'd0)
					tick <= tick;
				else
					tick <= tick + 1'b1;
				// one correction per reader edge
				fall_slot <= slot_used;
			end
			else
			begin
				// free run, wraps at 128
				tick <= tick + 1'b1;
			end
		end
	end

	// scope probe at the bit rate
	assign dbg = tick[3];

endmodule

//--- design/hi_iso14443a.sv
//--------------------------------------------------------------------
// ISO14443-A reader and sniffer front end, top level
// wires the field detector, tag demodulator, timebase and the ARM
// serial bridge together
//--------------------------------------------------------------------

`timescale 1ns/1ps

module hi_iso14443a
	import iso14443a_pkg::*;
#(
	// schmitt trigger thresholds on the reader's carrier
	parameter int hyst_high      = 16,
	parameter int hyst_low       = 8,
	// minimum filter swing that counts as a tag edge
	parameter int edge_threshold = 5
)
(
	input  logic              ck_1356meg,
	input  logic              ck_1356megb,
	input  logic              fdt_reset,
	input  logic [adc_w-1:0]  adc_d,
	input  logic [mode_w-1:0] mod_type,
	input  logic              ssp_dout,
	output logic              adc_clk,
	output logic              ssp_clk,
	output logic              ssp_frame,
	output logic              ssp_din,
	output logic              pwr_hi,
	output logic              dbg
);

	logic                     reader_level;
	logic                     reader_fall;
	logic                     reader_rise;
	logic                     deep_modulation;
	logic [tick_w-1:0]        tick;
	logic signed [filt_w-1:0] adc_filtered;
	logic                     curbit;

	// ADC runs off the carrier
	assign adc_clk = ck_1356meg;

	// reader to us
	reader_field_detect #(
		.hyst_high (hyst_high),
		.hyst_low  (hyst_low)
	) u_reader_field_detect (
		.ck_1356meg      (ck_1356meg),
		.fdt_reset       (fdt_reset),
		.adc_d           (adc_d),
		.reader_level    (reader_level),
		.reader_fall     (reader_fall),
		.reader_rise     (reader_rise),
		.deep_modulation (deep_modulation)
	);

	// tag to us
	tag_edge_filter u_tag_edge_filter (
		.ck_1356meg   (ck_1356meg),
		.adc_d        (adc_d),
		.adc_filtered (adc_filtered)
	);

	tag_mod_detector #(
		.edge_threshold (edge_threshold)
	) u_tag_mod_detector (
		.ck_1356meg      (ck_1356meg),
		.fdt_reset       (fdt_reset),
		.tick            (tick),
		.mod_type        (mod_type),
		.deep_modulation (deep_modulation),
		.reader_rise     (reader_rise),
		.adc_filtered    (adc_filtered),
		.curbit          (curbit)
	);

	carrier_timebase u_carrier_timebase (
		.ck_1356meg      (ck_1356meg),
		.fdt_reset       (fdt_reset),
		.mod_type        (mod_type),
		.deep_modulation (deep_modulation),
		.reader_fall     (reader_fall),
		.tick            (tick),
		.dbg             (dbg)
	);

	// ARM link and antenna
	ssp_bridge u_ssp_bridge (
		.ck_1356meg      (ck_1356meg),
		.ck_1356megb     (ck_1356megb),
		.fdt_reset       (fdt_reset),
		.tick            (tick),
		.mod_type        (mod_type),
		.reader_level    (reader_level),
		.deep_modulation (deep_modulation),
		.curbit          (curbit),
		.ssp_dout        (ssp_dout),
		.ssp_clk         (ssp_clk),
		.ssp_frame       (ssp_frame),
		.ssp_din         (ssp_din),
		.pwr_hi          (pwr_hi)
	);

endmodule

//--- design/ssp_bridge.sv
//--------------------------------------------------------------------
// SSP bridge to the ARM
// serial clock and frame, sniffer byte shifter, reader listen data
// and the carrier key for reader transmission
//--------------------------------------------------------------------

`timescale 1ns/1ps

module ssp_bridge
	import iso14443a_pkg::*;
(
	input  logic              ck_1356meg,
	input  logic              ck_1356megb,
	input  logic              fdt_reset,
	input  logic [tick_w-1:0] tick,
	input  logic [mode_w-1:0] mod_type,
	input  logic              reader_level,
	input  logic              deep_modulation,
	input  logic              curbit,
	input  logic              ssp_dout,
	output logic              ssp_clk,
	output logic              ssp_frame,
	output logic              ssp_din,
	output logic              pwr_hi
);

	logic       sniffing;
	// four bit-slot histories of reader and tag
	logic [3:0] reader_hist;
	logic [3:0] tag_hist;
	// byte on its way to the ARM, MSB first
	logic [7:0] to_arm;
	// registered ssp_dout, high means carrier off
	logic       carrier_key;

	assign sniffing = (mod_type == mode_sniffer);

	// ------------------------------------------------------------------
	// ssp clock and frame
	// ------------------------------------------------------------------

	always_ff @(negedge ck_1356meg)
	begin
		if (fdt_reset)
		begin
			ssp_clk   <= 1'b0;
			ssp_frame <= 1'b0;
		end
		else if (sniffing)
		begin
			// clock = carrier / 8, frame = carrier / 64
			if (tick[2:0] == 3'd0)
				ssp_clk <= 1'b1;
			if (tick[2:0] == 3'd4)
				ssp_clk <= 1'b0;
			if (tick[5:0] == 6'd0)
				ssp_frame <= 1'b1;
			if (tick[5:0] == 6'd8)
				ssp_frame <= 1'b0;
		end
		else
		begin
			// clock = carrier / 16, frame = carrier / 128
			if (tick[3:0] == 4'd0)
				ssp_clk <= 1'b1;
			if (tick[3:0] == 4'd8)
				ssp_clk <= 1'b0;
			if (tick == 7'd7)
				ssp_frame <= 1'b1;
			if (tick == 7'd23)
				ssp_frame <= 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// sniffer byte assembly
	// ------------------------------------------------------------------

	always_ff @(negedge ck_1356meg)
	begin
		// one sample of each side per bit slot
		if (sniffing && tick[3:0] == 4'd0)
		begin
			reader_hist <= {reader_hist[2:0], reader_level};
			tag_hist    <= {tag_hist[2:0], curbit};
		end

		if (sniffing && tick[5:0] == 6'd63)
		begin
			// while the reader sends, tag slots carry nothing useful
			if (deep_modulation)
				to_arm <= {reader_hist, 4'b0000};
			else
				to_arm <= {reader_hist, tag_hist};
		end
		else if (sniffing && tick[2:0] == 3'd0 && tick[5:0] != 6'd0)
		begin
			// next bit every ssp_clk, skip the slot right after a load
			to_arm <= {to_arm[6:0], 1'b0};
		end
	end

	// ------------------------------------------------------------------
	// data to the ARM
	// ------------------------------------------------------------------

	always_ff @(negedge ck_1356meg)
	begin
		if (fdt_reset)
			ssp_din <= 1'b0;
		else if (sniffing)
			ssp_din <= to_arm[7];
		else if (mod_type != mode_reader_listen)
			// reader mod and tag simulation codes send nothing
			ssp_din <= 1'b0;
		else if (tick[3:0] == 4'd0)
			// demodulated tag bit, once per bit slot
			ssp_din <= curbit;
	end

	// ------------------------------------------------------------------
	// antenna driver
	// ------------------------------------------------------------------

	always_ff @(negedge ck_1356meg)
	begin
		if (fdt_reset)
			carrier_key <= 1'b0;
		else
			carrier_key <= ssp_dout;
	end

	// carrier on while listening, keyed off by a pause in reader mod
	assign pwr_hi = ck_1356megb & (((mod_type == mode_reader_mod) & ~carrier_key)
		| (mod_type == mode_reader_listen));

endmodule

//--- reader_rx/reader_field_detect.sv
//--------------------------------------------------------------------
// reader field detector
// schmitt trigger on the reader's carrier, 100% modulation detect
// and edge strobes of the shaped reader signal
//--------------------------------------------------------------------

`timescale 1ns/1ps

module reader_field_detect
	import iso14443a_pkg::*;
#(
	parameter int hyst_high = 16,
	parameter int hyst_low  = 8
)
(
	input  logic             ck_1356meg,
	input  logic             fdt_reset,
	input  logic [adc_w-1:0] adc_d,
	output logic             reader_level,
	output logic             reader_fall,
	output logic             reader_rise,
	output logic             deep_modulation
);

	localparam int zero_cnt_w = $clog2(deep_mod_ticks);
	localparam int idle_cnt_w = $clog2(deep_idle_ticks);

	// run lengths of zero and non-zero samples
	logic [zero_cnt_w-1:0] zero_run;
	logic [idle_cnt_w-1:0] idle_run;
	// shaped level one tick back, for the edge strobes
	logic                  reader_level_d;

	// ------------------------------------------------------------------
	// hysteresis comparator
	// ------------------------------------------------------------------

	always_ff @(negedge ck_1356meg)
	begin
		if (fdt_reset)
		begin
			// unmodulated carrier assumed
			reader_level   <= 1'b1;
			reader_level_d <= 1'b1;
		end
		else
		begin
			reader_level_d <= reader_level;
			// between the thresholds the old level holds
			if (adc_d >= adc_w'(hyst_high))
				reader_level <= 1'b1;
			else if (adc_d < adc_w'(hyst_low))
				reader_level <= 1'b0;
		end
	end

	// edge strobes, one tick wide
	assign reader_fall = reader_level_d & ~reader_level;
	assign reader_rise = ~reader_level_d & reader_level;

	// ------------------------------------------------------------------
	// deep modulation detector
	// ------------------------------------------------------------------

	always_ff @(negedge ck_1356meg)
	begin
		if (fdt_reset)
		begin
			zero_run        <= '0;
			idle_run        <= '0;
			deep_modulation <= 1'b0;
		end
		else if (adc_d == '0)
		begin
			// carrier off, a non-zero run is broken
			idle_run <= '0;
			if (zero_run == zero_cnt_w'(deep_mod_ticks - 1))
				deep_modulation <= 1'b1;
			else
				zero_run <= zero_run + 1'b1;
		end
		else
		begin
			zero_run <= '0;
			// reader quiet long enough, tag may be answering
			if (idle_run == idle_cnt_w'(deep_idle_ticks - 1))
				deep_modulation <= 1'b0;
			else
				idle_run <= idle_run + 1'b1;
		end
	end

endmodule

//--- src.f
common/iso14443a_pkg.sv
reader_rx/reader_field_detect.sv
tag_rx/tag_edge_filter.sv
tag_rx/tag_mod_detector.sv
design/carrier_timebase.sv
design/ssp_bridge.sv
design/hi_iso14443a.sv
bench/tb_hi_iso14443a.sv

//--- tag_rx/tag_edge_filter.sv
//--------------------------------------------------------------------
// tag edge filter
// gaussian derivative over the last five ADC samples, used to find
// the edges of the tag's subcarrier
//--------------------------------------------------------------------

`timescale 1ns/1ps

module tag_edge_filter
	import iso14443a_pkg::*;
(
	input  logic                     ck_1356meg,
	input  logic [adc_w-1:0]         adc_d,
	output logic signed [filt_w-1:0] adc_filtered
);

	// prev_1 is the newest stored sample, prev_4 the oldest
	logic [adc_w-1:0] prev_1;
	logic [adc_w-1:0] prev_2;
	logic [adc_w-1:0] prev_3;
	logic [adc_w-1:0] prev_4;

	// unsigned partial sums, two bits of headroom
	logic [adc_w+1:0] older_sum;
	logic [adc_w+1:0] newer_sum;

	// sample delay line
	always_ff @(negedge ck_1356meg)
	begin
		prev_4 <= prev_3;
		prev_3 <= prev_2;
		prev_2 <= prev_1;
		prev_1 <= adc_d;
	end

	// taps 2, 1, 0, -1, -2 from oldest to current
	// prev_2 sits at the centre with weight zero
	assign older_sum = {prev_4, 1'b0} + (adc_w+2)'(prev_3);
	assign newer_sum = {adc_d, 1'b0} + (adc_w+2)'(prev_1);

	// positive on a falling signal, negative on a rising one
	assign adc_filtered = $signed({1'b0, older_sum}) - $signed({1'b0, newer_sum});

endmodule

//--- tag_rx/tag_mod_detector.sv
//--------------------------------------------------------------------
// tag modulation detector
// picks the detection window phase, tracks the steepest filter
// edges inside it and decides whether the tag modulated
//--------------------------------------------------------------------

`timescale 1ns/1ps

module tag_mod_detector
	import iso14443a_pkg::*;
#(
	parameter int edge_threshold = 5
)
(
	input  logic                     ck_1356meg,
	input  logic                     fdt_reset,
	input  logic [tick_w-1:0]        tick,
	input  logic [mode_w-1:0]        mod_type,
	input  logic                     deep_modulation,
	input  logic                     reader_rise,
	input  logic signed [filt_w-1:0] adc_filtered,
	output logic                     curbit
);

	// slot of the window start within a 16 tick bit
	logic [3:0]               window_phase;
	// steepest falling edge (positive) and rising edge (negative)
	logic signed [filt_w-1:0] fall_peak;
	logic signed [filt_w-1:0] rise_peak;
	logic [3:0]               slot;

	assign slot = tick[3:0];

	// ------------------------------------------------------------------
	// window phase
	// ------------------------------------------------------------------

	always_ff @(negedge ck_1356meg)
	begin
		if (fdt_reset)
			window_phase <= listen_window_phase;
		else if (mod_type == mode_reader_listen)
			// our own reader timing, the answer lands at a fixed slot
			window_phase <= listen_window_phase;
		else if (mod_type == mode_sniffer && reader_rise && deep_modulation)
			// end of a reader pause, back off by the front end lag
			window_phase <= slot - sniff_window_offset;
	end

	// ------------------------------------------------------------------
	// peak tracking and bit decision
	// ------------------------------------------------------------------

	always_ff @(negedge ck_1356meg)
	begin
		if (fdt_reset)
		begin
			curbit    <= 1'b0;
			fall_peak <= '0;
			rise_peak <= '0;
		end
		else if (slot == window_phase)
		begin
			// modulation needs both a falling and a rising edge
			curbit    <= (fall_peak > edge_threshold) && (rise_peak < -edge_threshold);
			fall_peak <= '0;
			rise_peak <= '0;
		end
		else if (adc_filtered > 0)
		begin
			if (adc_filtered > fall_peak)
				fall_peak <= adc_filtered;
		end
		else
		begin
			if (adc_filtered < rise_peak)
				rise_peak <= adc_filtered;
		end
	end

endmodule
